// ==== all.f ====
+incdir+src
src/memreq_link_pkg.sv
src/memreq_axi_pkg.sv
src/request_decoder.sv
src/write_burst_engine.sv
src/read_burst_engine.sv
src/response_encoder.sv
src/memreq_top.sv
bench/bench_clock.sv
bench/axi_mem_model.sv
bench/tb_memreq.sv

// ==== bench/axi_mem_model.sv ====
`timescale 1ns/1ps
`include "memreq_params.svh"

module axi_mem_model
  import memreq_axi_pkg::*;
(
  input  logic                          bus_clock,
  input  logic                          bus_reset,
  input  logic                          force_err_i,  // Error response on B and R
  input  logic                          wstall_i,     // Throttle wready
  input  logic                          awvalid_i,
  output logic                          awready_o,
  input  logic [`MEMREQ_ADDR_WIDTH-1:0] awaddr_i,
  input  logic [`MEMREQ_ID_WIDTH-1:0]   awid_i,
  input  logic                          wvalid_i,
  output logic                          wready_o,
  input  logic [`MEMREQ_DATA_WIDTH-1:0] wdata_i,
  input  logic                          wlast_i,
  output logic                          bvalid_o,
  input  logic                          bready_i,
  output logic [1:0]                    bresp_o,
  output logic [`MEMREQ_ID_WIDTH-1:0]   bid_o,
  input  logic                          arvalid_i,
  output logic                          arready_o,
  input  logic [`MEMREQ_ADDR_WIDTH-1:0] araddr_i,
  input  logic [`MEMREQ_ID_WIDTH-1:0]   arid_i,
  input  logic [7:0]                    arlen_i,
  output logic                          rvalid_o,
  input  logic                          rready_i,
  output logic                          rlast_o,
  output logic [1:0]                    rresp_o,
  output logic [`MEMREQ_ID_WIDTH-1:0]   rid_o,
  output logic [`MEMREQ_DATA_WIDTH-1:0] rdata_o
);

  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic [`MEMREQ_DATA_WIDTH-1:0] mem [0:63];
  logic [5:0] widx_q, ridx_q;
  logic [7:0] rcnt_q, rlen_q;
  logic       wbusy_q, rbusy_q;
  logic [1:0] stall_cnt_q;

  assign awready_o = !wbusy_q && !bvalid_o;
  assign wready_o  = wbusy_q && (!wstall_i || stall_cnt_q == 2'b11);
  assign bresp_o   = force_err_i ? RESP_SLVERR : RESP_OKAY;
  assign arready_o = !rbusy_q;
  assign rvalid_o  = rbusy_q;
  assign rdata_o   = mem[ridx_q];
  assign rlast_o   = rcnt_q == rlen_q;
  assign rresp_o   = force_err_i ? RESP_SLVERR : RESP_OKAY;

  initial begin
    for (int i = 0; i < 64; i++) begin
      mem[6'(i)] = 32'hc0de0000 + 32'(i) * 32'h00000101;  // Differs per word
    end
  end

  always @(posedge bus_clock) begin
    if (wvalid_i && wready_o) begin
      mem[widx_q] <= wdata_i;
    end
  end

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      wbusy_q     <= 1'b0;
      bvalid_o    <= 1'b0;
      rbusy_q     <= 1'b0;
      stall_cnt_q <= '0;
    end else begin
      stall_cnt_q <= stall_cnt_q + 2'd1;
      if (awvalid_i && awready_o) begin
        wbusy_q <= 1'b1;
        widx_q  <= awaddr_i[7:2];
        bid_o   <= awid_i;
      end
      if (wvalid_i && wready_o) begin
        widx_q <= widx_q + 6'd1;
        if (wlast_i) begin
          wbusy_q  <= 1'b0;
          bvalid_o <= 1'b1;
        end
      end
      if (bvalid_o && bready_i) begin
        bvalid_o <= 1'b0;
      end
      if (arvalid_i && arready_o) begin
        rbusy_q <= 1'b1;
        ridx_q  <= araddr_i[7:2];
        rcnt_q  <= 8'd0;
        rlen_q  <= arlen_i;
        rid_o   <= arid_i;
      end
      if (rvalid_o && rready_i) begin
        ridx_q <= ridx_q + 6'd1;
        rcnt_q <= rcnt_q + 8'd1;
        if (rlast_o) begin
          rbusy_q <= 1'b0;
        end
      end
    end
  end

endmodule

// ==== bench/bench_clock.sv ====
`timescale 1ns/1ps

module bench_clock (
  output logic bus_clock,
  output logic bus_reset
);

  initial begin
    bus_clock = 1'b0;
    forever #10 bus_clock = ~bus_clock;  // 20 ns period
  end

  initial begin
    bus_reset = 1'b1;
    repeat (4) @(posedge bus_clock);
    bus_reset <= 1'b0;
  end

endmodule

// ==== bench/tb_memreq.sv ====
`timescale 1ns/1ps
`include "memreq_params.svh"

module tb_memreq
  import memreq_link_pkg::*;
;

  localparam int TIMEOUT = 2000;

  logic bus_clock, bus_reset;
  logic s_tvalid, s_tready, s_tlast, m_tvalid, m_tready, m_tlast;
  logic [7:0] s_tdata, m_tdata;
  logic awvalid, awready, wvalid, wready, wlast, bvalid, bready;
  logic arvalid, arready, rvalid, rready, rlast;
  logic [`MEMREQ_ADDR_WIDTH-1:0] awaddr, araddr;
  logic [`MEMREQ_ID_WIDTH-1:0]   awid, bid, arid, rid;
  logic [7:0]                    awlen, arlen;
  logic [1:0]                    awburst, arburst, bresp, rresp;
  logic [`MEMREQ_STROBES-1:0]    wstrb;
  logic [`MEMREQ_DATA_WIDTH-1:0] wdata, rdata;
  logic force_err, wstall;

  integer     seed = 61;
  int         errors = 0;
  int         tests_run = 0;
  int         tests_failed = 0;
  int         errs_at_start;
  logic [7:0] pay [0:63];
  logic [7:0] rx_data [0:63];
  logic       rx_last [0:63];

  bench_clock i_clock (.bus_clock(bus_clock), .bus_reset(bus_reset));

  axi_mem_model i_mem (
    .bus_clock(bus_clock), .bus_reset(bus_reset),
    .force_err_i(force_err), .wstall_i(wstall),
    .awvalid_i(awvalid), .awready_o(awready), .awaddr_i(awaddr), .awid_i(awid),
    .wvalid_i(wvalid), .wready_o(wready), .wdata_i(wdata), .wlast_i(wlast),
    .bvalid_o(bvalid), .bready_i(bready), .bresp_o(bresp), .bid_o(bid),
    .arvalid_i(arvalid), .arready_o(arready), .araddr_i(araddr), .arid_i(arid),
    .arlen_i(arlen), .rvalid_o(rvalid), .rready_i(rready), .rlast_o(rlast),
    .rresp_o(rresp), .rid_o(rid), .rdata_o(rdata)
  );

  memreq_top i_memreq_top (
    .bus_clock(bus_clock), .bus_reset(bus_reset),
    .s_tvalid_i(s_tvalid), .s_tready_o(s_tready), .s_tlast_i(s_tlast), .s_tdata_i(s_tdata),
    .m_tvalid_o(m_tvalid), .m_tready_i(m_tready), .m_tlast_o(m_tlast), .m_tdata_o(m_tdata),
    .awvalid_o(awvalid), .awready_i(awready), .awaddr_o(awaddr), .awid_o(awid),
    .awlen_o(awlen), .awburst_o(awburst), .wvalid_o(wvalid), .wready_i(wready),
    .wlast_o(wlast), .wstrb_o(wstrb), .wdata_o(wdata), .bvalid_i(bvalid),
    .bready_o(bready), .bresp_i(bresp), .bid_i(bid),
    .arvalid_o(arvalid), .arready_i(arready), .araddr_o(araddr), .arid_o(arid),
    .arlen_o(arlen), .arburst_o(arburst), .rvalid_i(rvalid), .rready_o(rready),
    .rlast_i(rlast), .rresp_i(rresp), .rid_i(rid), .rdata_i(rdata)
  );

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("** Error %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_word(input string name, input logic [`MEMREQ_DATA_WIDTH-1:0] got,
                            input logic [`MEMREQ_DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("** Error %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // Reply code from its two fields
  function automatic logic [7:0] reply_code(input logic is_read, input logic ok);
    cmd_byte_u u;
    u.f.is_read = is_read;
    u.f.code    = is_read ? (ok ? 7'h01 : 7'h02) : (ok ? 7'h02 : 7'h03);
    return u.opcode;
  endfunction

  task automatic send_byte(input logic [7:0] data, input logic last);
    int   waited;
    logic ok;
    waited = 0;
    ok     = 1'b0;
    @(negedge bus_clock);
    s_tvalid = 1'b1;
    s_tdata  = data;
    s_tlast  = last;
    while (!ok) begin
      #1;
      ok = s_tready;  // Transfer on the coming rising edge
      @(posedge bus_clock);
      waited++;
      if (!ok && waited > TIMEOUT) begin
        $display("Timeout: link input never accepted byte %h", data);
        errors++;
        break;
      end
      if (!ok) @(negedge bus_clock);
    end
  endtask

  task automatic send_frame(input logic [7:0] cmd, input logic [7:0] len,
                            input logic [27:0] addr, input logic [3:0] id, input int n_pay);
    logic [7:0] hdr [0:5];
    int         i;
    hdr[0] = cmd;
    hdr[1] = len;
    hdr[2] = addr[7:0];
    hdr[3] = addr[15:8];
    hdr[4] = addr[23:16];
    hdr[5] = {id, addr[27:24]};
    for (i = 0; i < 6; i++) send_byte(hdr[i], n_pay == 0 && i == 5);
    for (i = 0; i < n_pay; i++) send_byte(pay[i], i == n_pay - 1);
    @(negedge bus_clock);
    s_tvalid = 1'b0;
    s_tlast  = 1'b0;
  endtask

  task automatic fill_payload(input int n);
    for (int i = 0; i < n; i++) pay[i] = 8'($random(seed));
  endtask

  task automatic recv_reply(input int n, input logic stall);
    int   got;
    int   waited;
    logic take;
    got    = 0;
    waited = 0;
    while (got < n && waited < TIMEOUT) begin
      @(negedge bus_clock);
      m_tready = stall ? 1'($random(seed)) : 1'b1;
      #1;
      take = m_tvalid && m_tready;
      if (take) begin
        rx_data[got] = m_tdata;
        rx_last[got] = m_tlast;
      end
      @(posedge bus_clock);
      if (take) got++;
      waited++;
    end
    if (got < n) begin
      $display("Timeout: reply stopped after %0d of %0d bytes", got, n);
      errors++;
    end
    @(negedge bus_clock);
    m_tready = 1'b1;
  endtask

  task automatic check_reply(input logic [7:0] code, input logic [3:0] id, input int n);
    check_byte("m_tdata_o (code)", rx_data[0], code);
    check_byte("m_tdata_o (id)", rx_data[1], {4'h0, id});
    for (int i = 0; i < n; i++) begin
      check_byte("m_tlast_o", {7'b0, rx_last[i]}, {7'b0, i == n - 1});
    end
  endtask

  task automatic do_store(input logic [27:0] addr, input int words, input logic [3:0] id,
                          input logic ok, input logic check_mem);
    int base;
    base = int'(addr[7:2]);
    fill_payload(4 * words);
    send_frame(OP_STORE, 8'(words - 1), addr, id, 4 * words);
    recv_reply(2, 1'b0);
    check_reply(reply_code(1'b0, ok), id, 2);
    check_word("awaddr_o", {4'h0, awaddr}, {4'h0, addr});
    check_byte("awlen_o", awlen, 8'(words - 1));
    check_byte("awburst_o", {6'b0, awburst}, 8'h01);  // INCR
    check_byte("wstrb_o", {4'b0, wstrb}, 8'h0f);
    for (int k = 0; check_mem && k < words; k++) begin
      check_word($sformatf("mem[%0d]", base + k), i_mem.mem[6'(base + k)],
                 {pay[4*k+3], pay[4*k+2], pay[4*k+1], pay[4*k]});
    end
  endtask

  task automatic do_fetch(input logic [27:0] addr, input int words, input logic [3:0] id,
                          input logic ok, input logic stall);
    int n;
    n = 2 + 4 * words;
    send_frame(OP_FETCH, 8'(words - 1), addr, id, 0);
    recv_reply(n, stall);
    check_reply(reply_code(1'b1, ok), id, n);
    check_word("araddr_o", {4'h0, araddr}, {4'h0, addr});
    check_byte("arlen_o", arlen, 8'(words - 1));
    check_byte("arburst_o", {6'b0, arburst}, 8'h01);  // INCR
    for (int i = 2; ok && i < n; i++) check_byte("m_tdata_o (data)", rx_data[i], pay[i-2]);
  endtask

  task automatic begin_test();
    errs_at_start = errors;
    tests_run++;
  endtask

  task automatic end_test(input string name);
    if (errors == errs_at_start) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: FAILED", name);
      tests_failed++;
    end
  endtask

  task automatic expect_silence(input int cycles);
    for (int c = 0; c < cycles; c++) begin
      @(negedge bus_clock);
      if (m_tvalid) begin
        $display("Unexpected reply byte %h after an unknown opcode", m_tdata);
        errors++;
        break;
      end
    end
  endtask

  initial begin
    int waited;
    s_tvalid  = 1'b0;
    s_tlast   = 1'b0;
    s_tdata   = 8'h00;
    m_tready  = 1'b1;
    force_err = 1'b0;
    wstall    = 1'b0;
    waited    = 0;
    @(negedge bus_clock);
    while (bus_reset && waited < TIMEOUT) begin
      @(negedge bus_clock);
      waited++;
    end
    if (bus_reset) begin
      $display("Timeout: reset never released");
      errors++;
    end

    begin_test();
    do_store(28'h5a3c710, 1, 4'h3, 1'b1, 1'b1);
    end_test("store_one_word");

    begin_test();
    do_store(28'hb96e840, 4, 4'h5, 1'b1, 1'b1);
    do_fetch(28'hb96e840, 4, 4'h6, 1'b1, 1'b0);
    end_test("store_fetch_burst");

    begin_test();
    force_err = 1'b1;
    do_store(28'h0000020, 1, 4'h7, 1'b0, 1'b0);
    do_fetch(28'h0000020, 1, 4'h8, 1'b0, 1'b0);
    force_err = 1'b0;
    end_test("error_responses");

    begin_test();
    wstall = 1'b1;
    do_store(28'h7d21580, 3, 4'ha, 1'b1, 1'b1);
    wstall = 1'b0;
    do_fetch(28'h7d21580, 3, 4'hb, 1'b1, 1'b1);
    end_test("backpressure");

    begin_test();
    fill_payload(2);
    send_frame(8'h55, 8'h01, 28'h0000000, 4'h9, 2);
    expect_silence(50);
    do_store(28'h00000c0, 1, 4'hc, 1'b1, 1'b1);
    end_test("unknown_opcode");

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the memreq testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_memreq -f all.f \
  --Mdir obj_dir -o sim_memreq
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_memreq > sim.log 2>&1
if [ $? -ne 0 ]; then
  cat sim.log
  echo "Simulation run returned an error"
  exit 1
fi
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
  exit 0
fi
exit 1

// ==== src/memreq_axi_pkg.sv ====
package memreq_axi_pkg;

  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [1:0] BURST_INCR = 2'b01;  // Tied off at the top level

endpackage

// ==== src/memreq_link_pkg.sv ====
package memreq_link_pkg;

  // Request opcodes
  localparam logic [7:0] OP_STORE = 8'h01;
  localparam logic [7:0] OP_FETCH = 8'h80;

  // Reply codes, bit 7 set on read replies
  localparam logic [7:0] RES_WDONE = 8'h02;
  localparam logic [7:0] RES_WFAIL = 8'h03;
  localparam logic [7:0] RES_RDATA = 8'h81;
  localparam logic [7:0] RES_RFAIL = 8'h82;

  typedef struct packed {
    logic       is_read;
    logic [6:0] code;
  } cmd_fields_t;

  // Command or reply byte, either whole or split into fields
  typedef union packed {
    logic [7:0]  opcode;
    cmd_fields_t f;
  } cmd_byte_u;

endpackage

// ==== src/memreq_params.svh ====
`ifndef MEMREQ_PARAMS_SVH
`define MEMREQ_PARAMS_SVH

`define MEMREQ_ADDR_WIDTH 28  // Byte address into memory
`define MEMREQ_ID_WIDTH 4
`define MEMREQ_DATA_WIDTH 32
`define MEMREQ_STROBES 4      // Bytes per word
`define MEMREQ_HDR_BYTES 6

`endif

// ==== src/memreq_top.sv ====
`timescale 1ns/1ps
`include "memreq_params.svh"

module memreq_top
  import memreq_axi_pkg::*;
(
  input  logic                          bus_clock,
  input  logic                          bus_reset,
  // Link input
  input  logic                          s_tvalid_i,
  output logic                          s_tready_o,
  input  logic                          s_tlast_i,
  input  logic [7:0]                    s_tdata_i,
  // Link output
  output logic                          m_tvalid_o,
  input  logic                          m_tready_i,
  output logic                          m_tlast_o,
  output logic [7:0]                    m_tdata_o,
  // AXI write
  output logic                          awvalid_o,
  input  logic                          awready_i,
  output logic [`MEMREQ_ADDR_WIDTH-1:0] awaddr_o,
  output logic [`MEMREQ_ID_WIDTH-1:0]   awid_o,
  output logic [7:0]                    awlen_o,
  output logic [1:0]                    awburst_o,
  output logic                          wvalid_o,
  input  logic                          wready_i,
  output logic                          wlast_o,
  output logic [`MEMREQ_STROBES-1:0]    wstrb_o,
  output logic [`MEMREQ_DATA_WIDTH-1:0] wdata_o,
  input  logic                          bvalid_i,
  output logic                          bready_o,
  input  logic [1:0]                    bresp_i,
  input  logic [`MEMREQ_ID_WIDTH-1:0]   bid_i,
  // AXI read
  output logic                          arvalid_o,
  input  logic                          arready_i,
  output logic [`MEMREQ_ADDR_WIDTH-1:0] araddr_o,
  output logic [`MEMREQ_ID_WIDTH-1:0]   arid_o,
  output logic [7:0]                    arlen_o,
  output logic [1:0]                    arburst_o,
  input  logic                          rvalid_i,
  output logic                          rready_o,
  input  logic                          rlast_i,
  input  logic [1:0]                    rresp_i,
  input  logic [`MEMREQ_ID_WIDTH-1:0]   rid_i,
  input  logic [`MEMREQ_DATA_WIDTH-1:0] rdata_i
);

  logic                          wr_start, rd_start;
  logic [`MEMREQ_ADDR_WIDTH-1:0] req_addr;
  logic [7:0]                    req_len;
  logic [`MEMREQ_ID_WIDTH-1:0]   req_id;
  logic                          pay_valid, pay_ready, pay_last;
  logic [7:0]                    pay_data;
  logic                          wr_resp_valid, wr_resp_ok;
  logic [`MEMREQ_ID_WIDTH-1:0]   wr_resp_id;
  logic                          rd_status_valid, rd_status_ok;
  logic [`MEMREQ_ID_WIDTH-1:0]   rd_status_id;
  logic                          rd_byte_valid, rd_byte_ready, rd_byte_last;
  logic [7:0]                    rd_byte_data;
  logic                          reply_done;

  // Only full-word incrementing bursts
  assign awburst_o = BURST_INCR;
  assign arburst_o = BURST_INCR;
  assign wstrb_o   = {`MEMREQ_STROBES{1'b1}};

  request_decoder i_request_decoder (
    .bus_clock(bus_clock), .bus_reset(bus_reset),
    .s_tvalid_i(s_tvalid_i), .s_tready_o(s_tready_o),
    .s_tlast_i(s_tlast_i), .s_tdata_i(s_tdata_i),
    .pay_ready_i(pay_ready), .reply_done_i(reply_done),
    .wr_start_o(wr_start), .rd_start_o(rd_start),
    .req_addr_o(req_addr), .req_len_o(req_len), .req_id_o(req_id),
    .pay_valid_o(pay_valid), .pay_data_o(pay_data), .pay_last_o(pay_last)
  );

  write_burst_engine i_write_burst_engine (
    .bus_clock(bus_clock), .bus_reset(bus_reset),
    .wr_start_i(wr_start), .req_addr_i(req_addr), .req_len_i(req_len), .req_id_i(req_id),
    .pay_valid_i(pay_valid), .pay_data_i(pay_data), .pay_last_i(pay_last),
    .pay_ready_o(pay_ready),
    .awvalid_o(awvalid_o), .awready_i(awready_i),
    .awaddr_o(awaddr_o), .awid_o(awid_o), .awlen_o(awlen_o),
    .wvalid_o(wvalid_o), .wready_i(wready_i), .wdata_o(wdata_o), .wlast_o(wlast_o),
    .bvalid_i(bvalid_i), .bready_o(bready_o), .bresp_i(bresp_i), .bid_i(bid_i),
    .wr_resp_valid_o(wr_resp_valid), .wr_resp_ok_o(wr_resp_ok), .wr_resp_id_o(wr_resp_id)
  );

  read_burst_engine i_read_burst_engine (
    .bus_clock(bus_clock), .bus_reset(bus_reset),
    .rd_start_i(rd_start), .req_addr_i(req_addr), .req_len_i(req_len), .req_id_i(req_id),
    .arvalid_o(arvalid_o), .arready_i(arready_i),
    .araddr_o(araddr_o), .arid_o(arid_o), .arlen_o(arlen_o),
    .rvalid_i(rvalid_i), .rready_o(rready_o), .rlast_i(rlast_i),
    .rresp_i(rresp_i), .rid_i(rid_i), .rdata_i(rdata_i),
    .rd_status_valid_o(rd_status_valid), .rd_status_ok_o(rd_status_ok),
    .rd_status_id_o(rd_status_id),
    .rd_byte_valid_o(rd_byte_valid), .rd_byte_ready_i(rd_byte_ready),
    .rd_byte_data_o(rd_byte_data), .rd_byte_last_o(rd_byte_last)
  );

  response_encoder i_response_encoder (
    .bus_clock(bus_clock), .bus_reset(bus_reset),
    .wr_resp_valid_i(wr_resp_valid), .wr_resp_ok_i(wr_resp_ok), .wr_resp_id_i(wr_resp_id),
    .rd_status_valid_i(rd_status_valid), .rd_status_ok_i(rd_status_ok),
    .rd_status_id_i(rd_status_id),
    .rd_byte_valid_i(rd_byte_valid), .rd_byte_ready_o(rd_byte_ready),
    .rd_byte_data_i(rd_byte_data), .rd_byte_last_i(rd_byte_last),
    .m_tvalid_o(m_tvalid_o), .m_tready_i(m_tready_i),
    .m_tlast_o(m_tlast_o), .m_tdata_o(m_tdata_o),
    .reply_done_o(reply_done)
  );

endmodule

// ==== src/read_burst_engine.sv ====
`timescale 1ns/1ps
`include "memreq_params.svh"

module read_burst_engine
  import memreq_axi_pkg::*;
(
  input  logic                          bus_clock,
  input  logic                          bus_reset,
  input  logic                          rd_start_i,
  input  logic [`MEMREQ_ADDR_WIDTH-1:0] req_addr_i,
  input  logic [7:0]                    req_len_i,
  input  logic [`MEMREQ_ID_WIDTH-1:0]   req_id_i,
  output logic                          arvalid_o,
  input  logic                          arready_i,
  output logic [`MEMREQ_ADDR_WIDTH-1:0] araddr_o,
  output logic [`MEMREQ_ID_WIDTH-1:0]   arid_o,
  output logic [7:0]                    arlen_o,
  input  logic                          rvalid_i,
  output logic                          rready_o,
  input  logic                          rlast_i,
  input  logic [1:0]                    rresp_i,
  input  logic [`MEMREQ_ID_WIDTH-1:0]   rid_i,
  input  logic [`MEMREQ_DATA_WIDTH-1:0] rdata_i,
  output logic                          rd_status_valid_o,
  output logic                          rd_status_ok_o,
  output logic [`MEMREQ_ID_WIDTH-1:0]   rd_status_id_o,
  output logic                          rd_byte_valid_o,
  input  logic                          rd_byte_ready_i,
  output logic [7:0]                    rd_byte_data_o,
  output logic                          rd_byte_last_o
);

  localparam int LANE_W = $clog2(`MEMREQ_STROBES);
  localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(`MEMREQ_STROBES - 1);

  localparam logic [1:0] PH_IDLE = 2'd0;
  localparam logic [1:0] PH_ADDR = 2'd1;
  localparam logic [1:0] PH_DATA = 2'd2;

  logic [1:0]                    phase_q;
  logic [LANE_W-1:0]             lane_q;
  logic                          full_q;
  logic                          first_q;  // Next beat carries the status
  logic                          last_q;
  logic [`MEMREQ_DATA_WIDTH-1:0] word_q;
  logic                          beat_w;
  logic                          byte_w;

  assign beat_w = rvalid_i && rready_o;
  assign byte_w = rd_byte_valid_o && rd_byte_ready_i;

  assign arvalid_o       = phase_q == PH_ADDR;
  assign rready_o        = (phase_q == PH_DATA) && !full_q;
  assign rd_byte_valid_o = full_q;
  assign rd_byte_data_o  = word_q[7:0];
  assign rd_byte_last_o  = last_q && (lane_q == LAST_LANE);

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      phase_q           <= PH_IDLE;
      lane_q            <= '0;
      full_q            <= 1'b0;
      first_q           <= 1'b0;
      rd_status_valid_o <= 1'b0;
    end else begin
      rd_status_valid_o <= 1'b0;
      if (byte_w) begin
        lane_q <= lane_q + LANE_W'(1);
        if (lane_q == LAST_LANE) begin
          full_q <= 1'b0;
        end
      end
      case (phase_q)
        PH_IDLE: begin
          if (rd_start_i) begin
            phase_q <= PH_ADDR;
          end
        end
        PH_ADDR: begin
          if (arready_i) begin
            phase_q <= PH_DATA;
            first_q <= 1'b1;
          end
        end
        default: begin
          if (beat_w) begin
            full_q            <= 1'b1;
            first_q           <= 1'b0;
            rd_status_valid_o <= first_q;
            if (rlast_i) begin
              phase_q <= PH_IDLE;  // Holder still drains its bytes
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge bus_clock) begin
    if (rd_start_i) begin
      araddr_o <= req_addr_i;
      arid_o   <= req_id_i;
      arlen_o  <= req_len_i;
    end
    if (beat_w) begin
      word_q <= rdata_i;
      last_q <= rlast_i;
    end else if (byte_w) begin
      word_q <= word_q >> 8;  // LSB first
    end
    if (beat_w && first_q) begin
      rd_status_ok_o <= rresp_i == RESP_OKAY;
      rd_status_id_o <= rid_i;
    end
  end

endmodule

// ==== src/request_decoder.sv ====
`timescale 1ns/1ps
`include "memreq_params.svh"

module request_decoder
  import memreq_link_pkg::*;
(
  input  logic                          bus_clock,
  input  logic                          bus_reset,
  input  logic                          s_tvalid_i,
  output logic                          s_tready_o,
  input  logic                          s_tlast_i,
  input  logic [7:0]                    s_tdata_i,
  input  logic                          pay_ready_i,
  input  logic                          reply_done_i,
  output logic                          wr_start_o,
  output logic                          rd_start_o,
  output logic [`MEMREQ_ADDR_WIDTH-1:0] req_addr_o,
  output logic [7:0]                    req_len_o,
  output logic [`MEMREQ_ID_WIDTH-1:0]   req_id_o,
  output logic                          pay_valid_o,
  output logic [7:0]                    pay_data_o,
  output logic                          pay_last_o
);

  localparam logic [1:0] ST_HDR   = 2'd0;
  localparam logic [1:0] ST_PAY   = 2'd1;
  localparam logic [1:0] ST_WAIT  = 2'd2;  // Until the reply is out
  localparam logic [1:0] ST_DRAIN = 2'd3;  // Unknown opcode, skip to tlast

  logic [1:0] state_q;
  logic [2:0] idx_q;
  cmd_byte_u  cmd_q;
  logic       known_w;
  logic       take_w;
  logic       hdr_end_w;

  assign known_w   = (cmd_q.opcode == OP_STORE) || (cmd_q.opcode == OP_FETCH);
  assign take_w    = s_tvalid_i && s_tready_o;
  assign hdr_end_w = idx_q == 3'(`MEMREQ_HDR_BYTES - 1);

  always_comb begin
    case (state_q)
      ST_HDR, ST_DRAIN: s_tready_o = 1'b1;
      ST_PAY:           s_tready_o = pay_ready_i;  // Write engine back-pressure
      default:          s_tready_o = 1'b0;
    endcase
  end

  // Payload passes straight through
  assign pay_valid_o = (state_q == ST_PAY) && s_tvalid_i;
  assign pay_data_o  = s_tdata_i;
  assign pay_last_o  = s_tlast_i;

  always_ff @(posedge bus_clock) begin
    if (state_q == ST_HDR && take_w) begin
      case (idx_q)
        3'd0:    cmd_q.opcode <= s_tdata_i;
        3'd1:    req_len_o <= s_tdata_i;
        3'd2:    req_addr_o[7:0] <= s_tdata_i;
        3'd3:    req_addr_o[15:8] <= s_tdata_i;
        3'd4:    req_addr_o[23:16] <= s_tdata_i;
        default: {req_id_o, req_addr_o[`MEMREQ_ADDR_WIDTH-1:24]} <= s_tdata_i;
      endcase
    end
  end

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      state_q    <= ST_HDR;
      idx_q      <= 3'd0;
      wr_start_o <= 1'b0;
      rd_start_o <= 1'b0;
    end else begin
      wr_start_o <= 1'b0;
      rd_start_o <= 1'b0;
      case (state_q)
        ST_HDR: begin
          if (take_w) begin
            idx_q <= idx_q + 3'd1;
            if (hdr_end_w && known_w) begin
              idx_q      <= 3'd0;
              wr_start_o <= !cmd_q.f.is_read;
              rd_start_o <= cmd_q.f.is_read;
              state_q    <= cmd_q.f.is_read ? ST_WAIT : ST_PAY;
            end else if (s_tlast_i) begin
              idx_q <= 3'd0;  // Short frame, nothing to do
            end else if (hdr_end_w) begin
              idx_q   <= 3'd0;
              state_q <= ST_DRAIN;
            end
          end
        end
        ST_PAY: begin
          if (take_w && s_tlast_i) begin
            state_q <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (reply_done_i) begin
            state_q <= ST_HDR;
          end
        end
        default: begin
          if (take_w && s_tlast_i) begin
            state_q <= ST_HDR;
          end
        end
      endcase
    end
  end

endmodule

// ==== src/response_encoder.sv ====
`timescale 1ns/1ps
`include "memreq_params.svh"

module response_encoder
  import memreq_link_pkg::*;
(
  input  logic                        bus_clock,
  input  logic                        bus_reset,
  input  logic                        wr_resp_valid_i,
  input  logic                        wr_resp_ok_i,
  input  logic [`MEMREQ_ID_WIDTH-1:0] wr_resp_id_i,
  input  logic                        rd_status_valid_i,
  input  logic                        rd_status_ok_i,
  input  logic [`MEMREQ_ID_WIDTH-1:0] rd_status_id_i,
  input  logic                        rd_byte_valid_i,
  output logic                        rd_byte_ready_o,
  input  logic [7:0]                  rd_byte_data_i,
  input  logic                        rd_byte_last_i,
  output logic                        m_tvalid_o,
  input  logic                        m_tready_i,
  output logic                        m_tlast_o,
  output logic [7:0]                  m_tdata_o,
  output logic                        reply_done_o
);

  localparam int ID_PAD = 8 - `MEMREQ_ID_WIDTH;

  localparam logic [1:0] EN_IDLE = 2'd0;
  localparam logic [1:0] EN_CODE = 2'd1;
  localparam logic [1:0] EN_ID   = 2'd2;
  localparam logic [1:0] EN_DATA = 2'd3;

  logic [1:0] state_q;
  cmd_byte_u  code_q;  // is_read picks the read reply path
  logic [7:0] id_q;

  always_comb begin
    m_tvalid_o = 1'b0;
    m_tlast_o  = 1'b0;
    m_tdata_o  = rd_byte_data_i;
    case (state_q)
      EN_CODE: begin
        m_tvalid_o = 1'b1;
        m_tdata_o  = code_q.opcode;
      end
      EN_ID: begin
        m_tvalid_o = 1'b1;
        m_tlast_o  = !code_q.f.is_read;  // Writes end on the ID byte
        m_tdata_o  = id_q;
      end
      EN_DATA: begin
        m_tvalid_o = rd_byte_valid_i;
        m_tlast_o  = rd_byte_last_i;
      end
      default: m_tvalid_o = 1'b0;
    endcase
  end

  assign rd_byte_ready_o = (state_q == EN_DATA) && m_tready_i;
  assign reply_done_o    = m_tvalid_o && m_tready_i && m_tlast_o;

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      state_q <= EN_IDLE;
    end else begin
      case (state_q)
        EN_IDLE: begin
          if (wr_resp_valid_i || rd_status_valid_i) begin
            state_q <= EN_CODE;
          end
        end
        EN_CODE: begin
          if (m_tready_i) begin
            state_q <= EN_ID;
          end
        end
        EN_ID: begin
          if (m_tready_i) begin
            state_q <= code_q.f.is_read ? EN_DATA : EN_IDLE;
          end
        end
        default: begin
          if (reply_done_o) begin
            state_q <= EN_IDLE;
          end
        end
      endcase
    end
  end

  // Reply bytes load while idle and hold once the reply starts
  always_ff @(posedge bus_clock) begin
    if (state_q == EN_IDLE) begin
      if (rd_status_valid_i) begin
        code_q.opcode <= rd_status_ok_i ? RES_RDATA : RES_RFAIL;
        id_q          <= {{ID_PAD{1'b0}}, rd_status_id_i};
      end else begin
        code_q.opcode <= wr_resp_ok_i ? RES_WDONE : RES_WFAIL;
        id_q          <= {{ID_PAD{1'b0}}, wr_resp_id_i};
      end
    end
  end

endmodule

// ==== src/write_burst_engine.sv ====
`timescale 1ns/1ps
`include "memreq_params.svh"

module write_burst_engine
  import memreq_axi_pkg::*;
(
  input  logic                          bus_clock,
  input  logic                          bus_reset,
  input  logic                          wr_start_i,
  input  logic [`MEMREQ_ADDR_WIDTH-1:0] req_addr_i,
  input  logic [7:0]                    req_len_i,
  input  logic [`MEMREQ_ID_WIDTH-1:0]   req_id_i,
  input  logic                          pay_valid_i,
  input  logic [7:0]                    pay_data_i,
  input  logic                          pay_last_i,
  output logic                          pay_ready_o,
  output logic                          awvalid_o,
  input  logic                          awready_i,
  output logic [`MEMREQ_ADDR_WIDTH-1:0] awaddr_o,
  output logic [`MEMREQ_ID_WIDTH-1:0]   awid_o,
  output logic [7:0]                    awlen_o,
  output logic                          wvalid_o,
  input  logic                          wready_i,
  output logic [`MEMREQ_DATA_WIDTH-1:0] wdata_o,
  output logic                          wlast_o,
  input  logic                          bvalid_i,
  output logic                          bready_o,
  input  logic [1:0]                    bresp_i,
  input  logic [`MEMREQ_ID_WIDTH-1:0]   bid_i,
  output logic                          wr_resp_valid_o,
  output logic                          wr_resp_ok_o,
  output logic [`MEMREQ_ID_WIDTH-1:0]   wr_resp_id_o
);

  localparam int LANE_W = $clog2(`MEMREQ_STROBES);
  localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(`MEMREQ_STROBES - 1);

  localparam logic [1:0] PH_IDLE = 2'd0;
  localparam logic [1:0] PH_ADDR = 2'd1;
  localparam logic [1:0] PH_DATA = 2'd2;
  localparam logic [1:0] PH_RESP = 2'd3;

  logic [1:0]        phase_q;
  logic [LANE_W-1:0] lane_q;
  logic              full_q;  // Word waiting on wready

  assign awvalid_o   = phase_q == PH_ADDR;
  assign pay_ready_o = (phase_q == PH_DATA) && !full_q;
  assign wvalid_o    = full_q;
  assign bready_o    = phase_q == PH_RESP;

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      phase_q         <= PH_IDLE;
      lane_q          <= '0;
      full_q          <= 1'b0;
      wr_resp_valid_o <= 1'b0;
    end else begin
      wr_resp_valid_o <= 1'b0;
      case (phase_q)
        PH_IDLE: begin
          if (wr_start_i) begin
            phase_q <= PH_ADDR;
            lane_q  <= '0;
          end
        end
        PH_ADDR: begin
          if (awready_i) begin
            phase_q <= PH_DATA;
          end
        end
        PH_DATA: begin
          if (pay_valid_i && pay_ready_o) begin
            lane_q <= lane_q + LANE_W'(1);
            full_q <= lane_q == LAST_LANE;
          end
          if (wvalid_o && wready_i) begin
            full_q <= 1'b0;
            if (wlast_o) begin
              phase_q <= PH_RESP;
            end
          end
        end
        default: begin
          if (bvalid_i) begin
            phase_q         <= PH_IDLE;
            wr_resp_valid_o <= 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge bus_clock) begin
    if (wr_start_i) begin
      awaddr_o <= req_addr_i;
      awid_o   <= req_id_i;
      awlen_o  <= req_len_i;
    end
    // Little-endian, first byte ends up in bits 7:0
    if (pay_valid_i && pay_ready_o) begin
      wdata_o <= {pay_data_i, wdata_o[`MEMREQ_DATA_WIDTH-1:8]};
      wlast_o <= pay_last_i;
    end
    if (bvalid_i && bready_o) begin
      wr_resp_ok_o <= bresp_i == RESP_OKAY;
      wr_resp_id_o <= bid_i;
    end
  end

endmodule
